// ==== src/lc3b_cfg.svh ====
`ifndef LC3B_CFG_SVH
`define LC3B_CFG_SVH

// first instruction fetch address
`define LC3B_RESET_PC 16'h0000

// both byte lanes of a word write
`define LC3B_WSTRB_ALL 2'b11

`endif

// ==== src/lc3b_types.sv ====
package lc3b_types;

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0] lc3b_reg;
    typedef logic [2:0] lc3b_nzp;   // negative, zero, positive

    // full LC-3b opcode map, only part of it is executed
    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef enum logic [1:0] {
        alu_add  = 2'b00,
        alu_and  = 2'b01,
        alu_not  = 2'b10,
        alu_pass = 2'b11   // f = b
    } lc3b_aluop;

endpackage : lc3b_types

// ==== src/lc3b_ctrl_if.sv ====
`timescale 1ns/10ps

interface lc3b_ctrl_if;
    import lc3b_types::*;

    logic       load_pc;
    logic       load_ir;
    logic       load_regfile;
    logic       load_mar;
    logic       load_mdr;
    logic       load_cc;
    logic [1:0] pcmux_sel;       // pc+2, branch target, base register
    logic       marmux_sel;      // alu result, pc
    logic       mdrmux_sel;      // alu result, memory data
    logic [1:0] alumux_sel;      // reg b, imm5, offset6, reg a
    logic       regfilemux_sel;  // alu result, mdr
    logic       storemux_sel;    // src1 field, dest field
    lc3b_aluop  aluop;

    lc3b_opcode opcode;
    logic       inst5;
    logic       inst11;
    logic       branch_enable;

    modport control (
        output load_pc, load_ir, load_regfile, load_mar, load_mdr, load_cc,
        output pcmux_sel, marmux_sel, mdrmux_sel, alumux_sel, regfilemux_sel, storemux_sel,
        output aluop,
        input  opcode, inst5, inst11, branch_enable
    );

    modport datapath (
        input  load_pc, load_ir, load_regfile, load_mar, load_mdr, load_cc,
        input  pcmux_sel, marmux_sel, mdrmux_sel, alumux_sel, regfilemux_sel, storemux_sel,
        input  aluop,
        output opcode, inst5, inst11, branch_enable
    );

endinterface : lc3b_ctrl_if

// ==== src/lc3b_mem_if.sv ====
`timescale 1ns/10ps

interface lc3b_mem_if;
    import lc3b_types::*;

    logic     mem_read;
    logic     mem_write;
    lc3b_word mem_address;
    lc3b_word mem_wdata;
    lc3b_word mem_rdata;
    logic     mem_resp;   // one cycle pulse per request

    modport control (
        output mem_read, mem_write,
        input  mem_resp
    );

    modport datapath (
        output mem_address, mem_wdata,
        input  mem_rdata
    );

    modport master (
        input  mem_read, mem_write, mem_address, mem_wdata,
        output mem_rdata, mem_resp
    );

endinterface : lc3b_mem_if

// ==== src/regfile.sv ====
`timescale 1ns/10ps

module regfile (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 load,
    input  lc3b_types::lc3b_reg  src_a,
    input  lc3b_types::lc3b_reg  src_b,
    input  lc3b_types::lc3b_reg  dest,
    input  lc3b_types::lc3b_word in,
    output lc3b_types::lc3b_word reg_a,
    output lc3b_types::lc3b_word reg_b
);
    import lc3b_types::*;

    lc3b_word regs [8];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (load) begin
            regs[dest] <= in;
        end
    end

    assign reg_a = regs[src_a];   // async read
    assign reg_b = regs[src_b];

endmodule : regfile

// ==== src/alu.sv ====
`timescale 1ns/10ps

module alu (
    input  lc3b_types::lc3b_aluop aluop,
    input  lc3b_types::lc3b_word  a,
    input  lc3b_types::lc3b_word  b,
    output lc3b_types::lc3b_word  f
);
    import lc3b_types::*;

    always_comb begin
        case (aluop)
            alu_add: begin
                f = a + b;
            end
            alu_and: begin
                f = a & b;
            end
            alu_not: begin
                f = ~a;
            end
            default: begin
                f = b;   // pass, selected operand straight through
            end
        endcase
    end

endmodule : alu

// ==== src/datapath.sv ====
`timescale 1ns/10ps
`include "lc3b_cfg.svh"

module datapath (
    input logic           clk,
    input logic           rst,
    lc3b_ctrl_if.datapath ctrl,
    lc3b_mem_if.datapath  mem
);
    import lc3b_types::*;

    lc3b_word ir;
    lc3b_word pc;
    lc3b_word mar;
    lc3b_word mdr;
    lc3b_nzp  cc;
    lc3b_nzp  gencc_out;
    lc3b_reg  dest;
    lc3b_reg  src1;
    lc3b_reg  src2;
    lc3b_reg  storemux_out;
    lc3b_word reg_a;
    lc3b_word reg_b;
    lc3b_word sext5_out;
    lc3b_word adj6_out;
    lc3b_word adj9_out;
    lc3b_word pc_plus2;
    lc3b_word br_target;
    lc3b_word pcmux_out;
    lc3b_word alumux_out;
    lc3b_word alu_out;
    lc3b_word marmux_out;
    lc3b_word mdrmux_out;
    lc3b_word regfilemux_out;

    // instruction fields
    assign dest        = ir[11:9];   // also the nzp field of BR
    assign src1        = ir[8:6];
    assign src2        = ir[2:0];
    assign ctrl.opcode = lc3b_opcode'(ir[15:12]);
    assign ctrl.inst5  = ir[5];
    assign ctrl.inst11 = ir[11];

    assign sext5_out = {{11{ir[4]}}, ir[4:0]};
    assign adj6_out  = {{9{ir[5]}}, ir[5:0], 1'b0};   // word offset to byte offset
    assign adj9_out  = {{6{ir[8]}}, ir[8:0], 1'b0};
    assign pc_plus2  = pc + 16'd2;
    assign br_target = pc + adj9_out;

    always_comb begin
        case (ctrl.pcmux_sel)
            2'b01:   pcmux_out = br_target;
            2'b10:   pcmux_out = reg_a;   // jmp base register
            default: pcmux_out = pc_plus2;
        endcase
    end

    always_comb begin
        case (ctrl.alumux_sel)
            2'b00:   alumux_out = reg_b;
            2'b01:   alumux_out = sext5_out;
            2'b10:   alumux_out = adj6_out;
            default: alumux_out = reg_a;   // store data on its way to the mdr
        endcase
    end

    assign storemux_out   = ctrl.storemux_sel ? dest : src1;
    assign marmux_out     = ctrl.marmux_sel ? pc : alu_out;
    assign mdrmux_out     = ctrl.mdrmux_sel ? mem.mem_rdata : alu_out;
    assign regfilemux_out = ctrl.regfilemux_sel ? mdr : alu_out;

    always_comb begin
        if (regfilemux_out[15]) begin
            gencc_out = 3'b100;
        end else if (regfilemux_out == '0) begin
            gencc_out = 3'b010;
        end else begin
            gencc_out = 3'b001;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `LC3B_RESET_PC;
            cc <= '0;
        end else begin
            if (ctrl.load_pc) pc <= pcmux_out;
            if (ctrl.load_cc) cc <= gencc_out;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.load_ir)  ir  <= mdr;
        if (ctrl.load_mar) mar <= marmux_out;
        if (ctrl.load_mdr) mdr <= mdrmux_out;
    end

    assign ctrl.branch_enable = |(dest & cc);
    assign mem.mem_address    = mar;
    assign mem.mem_wdata      = mdr;

    regfile regfile_inst (
        .clk   (clk),
        .rst   (rst),
        .load  (ctrl.load_regfile),
        .src_a (storemux_out),
        .src_b (src2),
        .dest  (dest),
        .in    (regfilemux_out),
        .reg_a (reg_a),
        .reg_b (reg_b)
    );

    alu alu_inst (
        .aluop (ctrl.aluop),
        .a     (reg_a),
        .b     (alumux_out),
        .f     (alu_out)
    );

endmodule : datapath

// ==== src/control.sv ====
`timescale 1ns/10ps

module control (
    input logic          clk,
    input logic          rst,
    lc3b_ctrl_if.control ctrl,
    lc3b_mem_if.control  mem
);
    import lc3b_types::*;

    typedef enum logic [3:0] {
        fetch1, fetch2, fetch3, decode,
        calc, br, jmp,
        ldr1, ldr2, ldr3,
        str1, str2, str3
    } state_t;

    state_t state;
    state_t next_state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= fetch1;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            fetch1: next_state = fetch2;
            fetch2: if (mem.mem_resp) next_state = fetch3;
            fetch3: next_state = decode;
            decode: begin
                case (ctrl.opcode)
                    op_add, op_and, op_not: next_state = calc;
                    op_br:                  next_state = br;
                    op_jmp:                 next_state = ctrl.inst11 ? fetch1 : jmp;   // bits 11:9 must be zero
                    op_ldr:                 next_state = ldr1;
                    op_str:                 next_state = str1;
                    default:                next_state = fetch1;
                endcase
            end
            ldr1:   next_state = ldr2;
            ldr2:   if (mem.mem_resp) next_state = ldr3;
            str1:   next_state = str2;
            str2:   next_state = str3;
            str3:   if (mem.mem_resp) next_state = fetch1;
            default: next_state = fetch1;   // calc, br, jmp, ldr3
        endcase
    end

    always_comb begin
        ctrl.load_pc        = 1'b0;
        ctrl.load_ir        = 1'b0;
        ctrl.load_regfile   = 1'b0;
        ctrl.load_mar       = 1'b0;
        ctrl.load_mdr       = 1'b0;
        ctrl.load_cc        = 1'b0;
        ctrl.pcmux_sel      = 2'b00;
        ctrl.marmux_sel     = 1'b0;
        ctrl.mdrmux_sel     = 1'b0;
        ctrl.alumux_sel     = 2'b00;
        ctrl.regfilemux_sel = 1'b0;
        ctrl.storemux_sel   = 1'b0;
        ctrl.aluop          = alu_add;
        mem.mem_read        = 1'b0;
        mem.mem_write       = 1'b0;

        case (state)
            fetch1: begin
                ctrl.marmux_sel = 1'b1;   // mar <= pc
                ctrl.load_mar   = 1'b1;
            end
            fetch2, ldr2: begin
                mem.mem_read    = 1'b1;
                ctrl.mdrmux_sel = 1'b1;
                ctrl.load_mdr   = mem.mem_resp;
            end
            fetch3: begin
                ctrl.load_ir = 1'b1;
                ctrl.load_pc = 1'b1;   // pc + 2
            end
            calc: begin
                case (ctrl.opcode)
                    op_and:  ctrl.aluop = alu_and;
                    op_not:  ctrl.aluop = alu_not;
                    default: ctrl.aluop = alu_add;
                endcase
                ctrl.alumux_sel   = ctrl.inst5 ? 2'b01 : 2'b00;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc      = 1'b1;
            end
            br: begin
                ctrl.pcmux_sel = 2'b01;
                ctrl.load_pc   = ctrl.branch_enable;
            end
            jmp: begin
                ctrl.pcmux_sel = 2'b10;
                ctrl.load_pc   = 1'b1;
            end
            ldr1, str1: begin
                ctrl.alumux_sel = 2'b10;   // base + offset6
                ctrl.load_mar   = 1'b1;
            end
            ldr3: begin
                ctrl.regfilemux_sel = 1'b1;
                ctrl.load_regfile   = 1'b1;
                ctrl.load_cc        = 1'b1;
            end
            str2: begin
                ctrl.storemux_sel = 1'b1;
                ctrl.alumux_sel   = 2'b11;
                ctrl.aluop        = alu_pass;
                ctrl.load_mdr     = 1'b1;
            end
            str3: begin
                mem.mem_write = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule : control

// ==== src/axi_lite_master.sv ====
`timescale 1ns/10ps
`include "lc3b_cfg.svh"

module axi_lite_master (
    input  logic                 clk,
    input  logic                 rst,
    lc3b_mem_if.master           mem,
    output lc3b_types::lc3b_word araddr,
    output logic                 arvalid,
    input  logic                 arready,
    input  lc3b_types::lc3b_word rdata,
    input  logic                 rvalid,
    output logic                 rready,
    output lc3b_types::lc3b_word awaddr,
    output logic                 awvalid,
    input  logic                 awready,
    output lc3b_types::lc3b_word wdata,
    output logic [1:0]           wstrb,
    output logic                 wvalid,
    input  logic                 wready,
    input  logic                 bvalid,
    output logic                 bready
);
    import lc3b_types::*;

    typedef enum logic [2:0] {idle, rd, wr, wr_resp, done} state_t;

    state_t   state;
    lc3b_word rdata_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= idle;
            arvalid <= 1'b0;
            rready  <= 1'b0;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            bready  <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (mem.mem_read) begin
                        araddr  <= mem.mem_address;
                        arvalid <= 1'b1;
                        state   <= rd;
                    end else if (mem.mem_write) begin
                        awaddr  <= mem.mem_address;
                        wdata   <= mem.mem_wdata;
                        awvalid <= 1'b1;
                        wvalid  <= 1'b1;
                        state   <= wr;
                    end
                end
                rd: begin
                    if (arvalid && arready) begin
                        arvalid <= 1'b0;
                        rready  <= 1'b1;
                    end
                    if (rready && rvalid) begin
                        rready  <= 1'b0;
                        rdata_q <= rdata;
                        state   <= done;
                    end
                end
                wr: begin
                    // address and data channels complete independently
                    if (awready) awvalid <= 1'b0;
                    if (wready)  wvalid  <= 1'b0;
                    if ((!awvalid || awready) && (!wvalid || wready)) begin
                        bready <= 1'b1;
                        state  <= wr_resp;
                    end
                end
                wr_resp: begin
                    if (bvalid) begin
                        bready <= 1'b0;
                        state  <= done;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    assign wstrb         = `LC3B_WSTRB_ALL;
    assign mem.mem_resp  = (state == done);
    assign mem.mem_rdata = rdata_q;

endmodule : axi_lite_master

// ==== src/cpu.sv ====
`timescale 1ns/10ps

module cpu (
    input  logic                 clk,
    input  logic                 rst,
    output lc3b_types::lc3b_word araddr,
    output logic                 arvalid,
    input  logic                 arready,
    input  lc3b_types::lc3b_word rdata,
    input  logic                 rvalid,
    output logic                 rready,
    output lc3b_types::lc3b_word awaddr,
    output logic                 awvalid,
    input  logic                 awready,
    output lc3b_types::lc3b_word wdata,
    output logic [1:0]           wstrb,
    output logic                 wvalid,
    input  logic                 wready,
    input  logic                 bvalid,
    output logic                 bready
);

    lc3b_ctrl_if ctrl_if ();
    lc3b_mem_if  mem_if ();

    datapath datapath_inst (
        .clk  (clk),
        .rst  (rst),
        .ctrl (ctrl_if.datapath),
        .mem  (mem_if.datapath)
    );

    control control_inst (
        .clk  (clk),
        .rst  (rst),
        .ctrl (ctrl_if.control),
        .mem  (mem_if.control)
    );

    axi_lite_master axi_lite_master_inst (
        .clk     (clk),
        .rst     (rst),
        .mem     (mem_if.master),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rvalid  (rvalid),
        .rready  (rready),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bvalid  (bvalid),
        .bready  (bready)
    );

endmodule : cpu

// ==== tests/cpu_tb.sv ====
`timescale 1ns/10ps
`include "lc3b_cfg.svh"

module cpu_tb;

    localparam int TIMEOUT      = 2000;
    localparam int MEM_WORDS    = 64;
    localparam int PAIRS_BASE   = MEM_WORDS + 1;
    localparam int GOLDEN_WORDS = 81;
    localparam int FETCH_CHECKS = 6;
    localparam int EXTRA_READS  = 10;   // fetches watched after the last store
    localparam int T_FETCH      = 0;
    localparam int T_WRITES     = 1;
    localparam int T_AXI        = 2;
    localparam int T_COUNT      = 3;

    logic        clk;
    logic        rst;
    logic [15:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [15:0] rdata;
    logic        rvalid;
    logic        rready;
    logic [15:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [15:0] wdata;
    logic [1:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic        bvalid;
    logic        bready;

    logic [15:0] golden [0:GOLDEN_WORDS-1];
    logic [15:0] mem [0:MEM_WORDS-1];
    logic [15:0] read_addrs [$];
    int          expected_writes;
    int          write_count;
    int          errors [4];
    integer      seed;

    cpu cpu_inst (
        .clk     (clk),
        .rst     (rst),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rvalid  (rvalid),
        .rready  (rready),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bvalid  (bvalid),
        .bready  (bready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic step();
        @(posedge clk);
        #1;   // drive and sample just after the edge
    endtask

    function automatic int ready_delay();
        return $unsigned($random(seed)) % 4;
    endfunction

    task automatic check_value(input int test, input string name,
                               input logic [15:0] expected, input logic [15:0] actual);
        assert (actual === expected) else begin
            $display("[ERROR] %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            errors[test]++;
        end
    endtask

    task automatic check_held(input int test, input string name, input logic valid);
        assert (valid === 1'b1) else begin
            $display("%s dropped before its handshake at %0t ns", name, $time);
            errors[test]++;
        end
    endtask

    task automatic check_range(input logic [15:0] addr);
        assert (addr < 2 * MEM_WORDS) else begin
            $display("address %h at %0t ns is outside the memory image", addr, $time);
            errors[T_AXI]++;
        end
    endtask

    task automatic give_up(input string what);
        $display("timeout: no %s within %0d cycles", what, TIMEOUT);
        $display("Test failures found");
        $finish;
    endtask

    task automatic serve_read();
        logic [15:0] addr;
        int          delay;
        int          waited;

        addr = araddr;
        read_addrs.push_back(addr);
        check_range(addr);
        delay = ready_delay();
        repeat (delay) begin
            step();
            check_held(T_AXI, "arvalid", arvalid);
            check_value(T_AXI, "araddr", addr, araddr);
        end
        arready = 1'b1;
        step();
        arready = 1'b0;
        delay = ready_delay();
        repeat (delay) step();
        rdata  = mem[addr[6:1]];
        rvalid = 1'b1;
        waited = 0;
        while (!rready && waited < TIMEOUT) begin
            step();
            waited++;
        end
        if (!rready) begin
            give_up("rready");
        end
        step();
        rvalid = 1'b0;
    endtask

    task automatic serve_write();
        logic [15:0] addr;
        logic [15:0] data;
        logic        aw_done;
        logic        w_done;
        logic        aw_hs;
        logic        w_hs;
        int          aw_delay;
        int          w_delay;
        int          waited;

        addr = awaddr;
        data = wdata;
        assert (awvalid && wvalid) else begin
            $display("awvalid and wvalid did not rise together at %0t ns", $time);
            errors[T_AXI]++;
        end
        check_value(T_AXI, "wstrb", `LC3B_WSTRB_ALL, wstrb);
        aw_delay = ready_delay();
        w_delay  = ready_delay();
        aw_done  = 1'b0;
        w_done   = 1'b0;
        waited   = 0;
        while (!(aw_done && w_done) && waited < TIMEOUT) begin
            awready = !aw_done && waited >= aw_delay;   // each channel on its own delay
            wready  = !w_done && waited >= w_delay;
            aw_hs   = awready && awvalid;
            w_hs    = wready && wvalid;
            step();
            aw_done = aw_done || aw_hs;
            w_done  = w_done || w_hs;
            waited++;
            if (!aw_done) begin
                check_held(T_AXI, "awvalid", awvalid);
                check_value(T_AXI, "awaddr", addr, awaddr);
            end
            if (!w_done) begin
                check_held(T_AXI, "wvalid", wvalid);
                check_value(T_AXI, "wdata", data, wdata);
            end
        end
        awready = 1'b0;
        wready  = 1'b0;
        if (!(aw_done && w_done)) begin
            give_up("write address and data handshakes");
        end
        repeat (ready_delay()) step();
        bvalid = 1'b1;
        waited = 0;
        while (!bready && waited < TIMEOUT) begin
            step();
            waited++;
        end
        if (!bready) begin
            give_up("bready");
        end
        step();
        bvalid = 1'b0;

        check_range(addr);
        mem[addr[6:1]] = data;
        assert (write_count < expected_writes) else begin
            $display("unexpected write of %h to %h at %0t ns", data, addr, $time);
            errors[T_COUNT]++;
        end
        if (write_count < expected_writes) begin
            check_value(T_WRITES, "awaddr", golden[PAIRS_BASE + 2 * write_count], addr);
            check_value(T_WRITES, "wdata", golden[PAIRS_BASE + 2 * write_count + 1], data);
        end
        write_count++;
    endtask

    task automatic serve_bus();
        int idle;

        forever begin
            idle = 0;
            while (!arvalid && !awvalid && !wvalid && idle < TIMEOUT) begin
                step();
                idle++;
            end
            if (!arvalid && !awvalid && !wvalid) begin
                give_up("AXI request");
            end
            if (arvalid) begin
                serve_read();
            end else begin
                serve_write();
            end
        end
    endtask

    task automatic report_test(input int test, input string name);
        if (errors[test] == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d error(s)", name, errors[test]);
        end
    endtask

    initial begin
        int i;
        int waited;
        int reads_before;
        int failed_tests;
        int total_errors;

        rst     = 1'b1;
        arready = 1'b0;
        rdata   = '0;
        rvalid  = 1'b0;
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
        seed        = 32'he69e18d2;
        write_count = 0;
        for (i = 0; i < 4; i++) begin
            errors[i] = 0;
        end

        $readmemh("tests/cpu_golden.hex", golden);
        for (i = 0; i < MEM_WORDS; i++) begin
            mem[i] = golden[i];
        end
        expected_writes = golden[MEM_WORDS];
        if (PAIRS_BASE + 2 * expected_writes > GOLDEN_WORDS) begin
            expected_writes = (GOLDEN_WORDS - PAIRS_BASE) / 2;   // count larger than the file
        end

        repeat (2) step();
        rst = 1'b0;
        assert (!arvalid && !awvalid && !wvalid && !rready && !bready) else begin
            $display("AXI valid or ready outputs not low after reset at %0t ns", $time);
            errors[T_FETCH]++;
        end
        fork
            serve_bus();
        join_none

        waited = 0;
        while (read_addrs.size() < FETCH_CHECKS && waited < TIMEOUT) begin
            step();
            waited++;
        end
        if (read_addrs.size() < FETCH_CHECKS) begin
            give_up("instruction fetches");
        end
        for (i = 0; i < FETCH_CHECKS; i++) begin
            check_value(T_FETCH, "araddr", 16'(2 * i), read_addrs[i]);   // fetch starts at zero
        end
        report_test(T_FETCH, "reset_fetch");

        waited = 0;
        while (write_count < expected_writes && waited < TIMEOUT) begin
            step();
            waited++;
        end
        if (write_count < expected_writes) begin
            give_up("complete write sequence");
        end
        report_test(T_WRITES, "write_sequence");

        // the program ends in a branch to itself, so only fetches follow
        reads_before = read_addrs.size();
        waited = 0;
        while (read_addrs.size() < reads_before + EXTRA_READS && waited < TIMEOUT) begin
            step();
            waited++;
        end
        if (read_addrs.size() < reads_before + EXTRA_READS) begin
            give_up("fetches after the last write");
        end
        assert (write_count == expected_writes) else begin
            $display("saw %0d writes where %0d were expected", write_count, expected_writes);
            errors[T_COUNT]++;
        end
        report_test(T_AXI, "axi_rules");
        report_test(T_COUNT, "write_count");

        failed_tests = 0;
        total_errors = 0;
        for (i = 0; i < 4; i++) begin
            total_errors += errors[i];
            if (errors[i] != 0) begin
                failed_tests++;
            end
        end
        $display("tests run: 4, passed: %0d, failed: %0d, errors: %0d",
                 4 - failed_tests, failed_tests, total_errors);
        if (total_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule : cpu_tb

// ==== tests/cpu_golden.hex ====
// entries 0 to 63: memory image (program from word 0, data from word 32)
// entry 64: count of expected writes, then pairs of write address and write data
1225 147D 1642 58E6 9AFF 5D41 6E1F 77C0 // add, and, not, ldr base, first str
79C1 7BFF 75F8 6DFF 63CF 1D81 7DC2 0801 // stores with +/- offsets, loads, brn
73C3 54A0 0401 73C4 14BF 75C5 F025 0202 // brz taken skips 73C4, trap skipped
681E C100 73C6 79C7 0FFF 0000 0036 0050 // jmp over 73C6, self loop, constants
0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 1234
0000 0000 0000 0000 0000 0000 0000 0000
0008
0050 0007
0052 0006
004E FFF8
0040 0002
0054 122C
0056 1234
005A FFFF
005E 0036

// ==== list.f ====
+incdir+src
src/lc3b_types.sv
src/lc3b_ctrl_if.sv
src/lc3b_mem_if.sv
src/regfile.sv
src/alu.sv
src/datapath.sv
src/control.sv
src/axi_lite_master.sv
src/cpu.sv
tests/cpu_tb.sv

// ==== Bender.yml ====
package:
  name: lc3b_cpu

sources:
  - include_dirs:
      - src
    files:
      - src/lc3b_types.sv
      - src/lc3b_ctrl_if.sv
      - src/lc3b_mem_if.sv
      - src/regfile.sv
      - src/alu.sv
      - src/datapath.sv
      - src/control.sv
      - src/axi_lite_master.sv
      - src/cpu.sv
  - target: test
    include_dirs:
      - src
    files:
      - tests/cpu_tb.sv
